/* design/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	localparam int inst_addr_w = 10;
	localparam int data_addr_w = 8;
	localparam int rx_depth = 4;

	// primary opcodes
	localparam logic [5:0] op_special = 6'h00;
	localparam logic [5:0] op_j = 6'h02;
	localparam logic [5:0] op_beq = 6'h04;
	localparam logic [5:0] op_bne = 6'h05;
	localparam logic [5:0] op_addiu = 6'h09;
	localparam logic [5:0] op_ori = 6'h0d;
	localparam logic [5:0] op_lui = 6'h0f;
	localparam logic [5:0] op_lw = 6'h23;
	localparam logic [5:0] op_sw = 6'h2b;
	// link access, funct picks the direction
	localparam logic [5:0] op_uart = 6'h3f;

	localparam logic [5:0] fn_sll = 6'h00;
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or = 6'h25;
	localparam logic [5:0] fn_slt = 6'h2a;
	localparam logic [5:0] fn_in = 6'h01;
	localparam logic [5:0] fn_out = 6'h02;

	localparam logic [3:0] alu_add = 4'd0;
	localparam logic [3:0] alu_sub = 4'd1;
	localparam logic [3:0] alu_and = 4'd2;
	localparam logic [3:0] alu_or = 4'd3;
	localparam logic [3:0] alu_slt = 4'd4;
	localparam logic [3:0] alu_sll = 4'd5;
	localparam logic [3:0] alu_lui = 4'd6;

	localparam logic [1:0] wb_alu = 2'd0;
	localparam logic [1:0] wb_mem = 2'd1;
	localparam logic [1:0] wb_uart = 2'd2;

	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm;
		} i;
		struct packed {
			logic [5:0] opcode;
			logic [25:0] index;
		} j;
	} inst_word_t;

endpackage

`default_nettype wire

/* design/receiver_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module receiver_buffer (
	input logic CLK,
	input logic reset,
	input logic [7:0] rx_data,
	input logic rx_valid,
	input logic load,
	output logic imem_we,
	output logic [31:0] imem_data,
	output logic in_ready,
	output logic [31:0] in_word,
	input logic in_pop
);

	logic load_q, word_done, push, pop;
	logic [1:0] byte_cnt;
	logic [23:0] low_bytes;
	logic [31:0] queue [cpu_pkg::rx_depth];
	logic [$clog2(cpu_pkg::rx_depth)-1:0] head, tail;
	logic [$clog2(cpu_pkg::rx_depth):0] count;

	// a load edge restarts word assembly
	assign word_done = rx_valid && byte_cnt == 2'd3 && load == load_q;
	assign push = word_done && !load
		&& count != cpu_pkg::rx_depth[$clog2(cpu_pkg::rx_depth):0];
	assign pop = in_pop && in_ready;
	assign in_ready = count != '0;
	assign in_word = queue[head];

	always_ff @(posedge CLK) begin
		if (reset) begin
			load_q <= 1'b0;
			byte_cnt <= 2'd0;
			imem_we <= 1'b0;
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			load_q <= load;
			imem_we <= word_done && load;
			if (load != load_q) begin
				byte_cnt <= {1'b0, rx_valid};
			end else if (rx_valid) begin
				byte_cnt <= byte_cnt + 1'b1;
			end
			if (push) tail <= tail + 1'b1;
			if (pop) head <= head + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// byte 0 ends up in the low bits
	always_ff @(posedge CLK) begin
		if (rx_valid) low_bytes <= {rx_data, low_bytes[23:8]};
		if (word_done) imem_data <= {rx_data, low_bytes};
		if (push) queue[tail] <= {rx_data, low_bytes};
	end

endmodule

`default_nettype wire

/* design/sender_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module sender_buffer (
	input logic CLK,
	input logic reset,
	input logic out_start,
	input logic [31:0] out_word,
	output logic [7:0] tx_data,
	output logic tx_valid,
	output logic busy
);

	logic [23:0] rest;
	logic [1:0] left;

	always_ff @(posedge CLK) begin
		if (reset) begin
			tx_valid <= 1'b0;
			busy <= 1'b0;
			left <= 2'd0;
		end else if (out_start) begin
			tx_valid <= 1'b1;
			busy <= 1'b1;
			left <= 2'd3;
		end else if (left != 2'd0) begin
			tx_valid <= 1'b1;
			left <= left - 1'b1;
		end else begin
			tx_valid <= 1'b0;
			busy <= 1'b0;
		end
	end

	// least significant byte goes out first
	always_ff @(posedge CLK) begin
		if (out_start) begin
			tx_data <= out_word[7:0];
			rest <= out_word[31:8];
		end else begin
			tx_data <= rest[7:0];
			rest <= rest >> 8;
		end
	end

endmodule

`default_nettype wire

/* design/inst_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_fetch (
	input logic CLK,
	input logic reset,
	input logic load,
	input logic imem_we,
	input logic [31:0] imem_data,
	input logic start,
	input logic [cpu_pkg::inst_addr_w-1:0] next_pc,
	input logic busy,
	output logic fetch_valid,
	output cpu_pkg::inst_word_t inst,
	output logic [cpu_pkg::inst_addr_w-1:0] pc
);

	logic [31:0] imem [2**cpu_pkg::inst_addr_w];
	logic [cpu_pkg::inst_addr_w-1:0] load_addr, held_pc, fetch_addr;
	logic load_q, pending, first, issue;

	// program starts at 0 once load drops
	assign first = load_q && !load;
	assign issue = first || ((start || pending) && !busy && !load);
	assign fetch_addr = first ? '0 : (start ? next_pc : held_pc);

	always_ff @(posedge CLK) begin
		if (reset) begin
			load_q <= 1'b0;
			pending <= 1'b0;
			fetch_valid <= 1'b0;
			load_addr <= '0;
			pc <= '0;
		end else begin
			load_q <= load;
			fetch_valid <= issue;
			if (issue) pc <= fetch_addr;
			// a token arriving during load is dropped
			if (load || issue) begin
				pending <= 1'b0;
			end else if (start) begin
				pending <= 1'b1;
			end
			if (load && !load_q) begin
				load_addr <= '0;
			end else if (imem_we) begin
				load_addr <= load_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (start) held_pc <= next_pc;
		if (imem_we) imem[load_addr] <= imem_data;
		if (issue) inst <= imem[fetch_addr];
	end

endmodule

`default_nettype wire

/* design/inst_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
	input logic CLK,
	input logic reset,
	input logic fetch_valid,
	input cpu_pkg::inst_word_t inst,
	input logic [cpu_pkg::inst_addr_w-1:0] pc,
	output logic dec_valid,
	output logic [4:0] rs, rt, rd_dst,
	output logic [3:0] alu_op,
	output logic use_imm, sign_ext, mem_read, mem_write, reg_write,
	output logic [1:0] wb_src,
	output logic branch_eq, branch_ne, jump, uart_out,
	output logic [15:0] imm,
	output logic [cpu_pkg::inst_addr_w-1:0] jump_index, pc_out
);

	always_ff @(posedge CLK) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= fetch_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (fetch_valid) begin
			rs <= inst.r.rs;
			rt <= inst.r.rt;
			imm <= inst.i.imm;
			jump_index <= inst.j.index[cpu_pkg::inst_addr_w-1:0];
			pc_out <= pc;
			// defaults fit addiu
			rd_dst <= inst.i.rt;
			alu_op <= cpu_pkg::alu_add;
			use_imm <= 1'b1;
			sign_ext <= 1'b1;
			mem_read <= 1'b0;
			mem_write <= 1'b0;
			reg_write <= 1'b0;
			wb_src <= cpu_pkg::wb_alu;
			branch_eq <= 1'b0;
			branch_ne <= 1'b0;
			jump <= 1'b0;
			uart_out <= 1'b0;
			case (inst.r.opcode)
				cpu_pkg::op_special: begin
					rd_dst <= inst.r.rd;
					use_imm <= 1'b0;
					reg_write <= 1'b1;
					case (inst.r.funct)
						cpu_pkg::fn_addu: alu_op <= cpu_pkg::alu_add;
						cpu_pkg::fn_subu: alu_op <= cpu_pkg::alu_sub;
						cpu_pkg::fn_and: alu_op <= cpu_pkg::alu_and;
						cpu_pkg::fn_or: alu_op <= cpu_pkg::alu_or;
						cpu_pkg::fn_slt: alu_op <= cpu_pkg::alu_slt;
						cpu_pkg::fn_sll: alu_op <= cpu_pkg::alu_sll;
						default: alu_op <= cpu_pkg::alu_add;
					endcase
				end
				cpu_pkg::op_addiu: reg_write <= 1'b1;
				cpu_pkg::op_ori: begin
					reg_write <= 1'b1;
					sign_ext <= 1'b0;
					alu_op <= cpu_pkg::alu_or;
				end
				cpu_pkg::op_lui: begin
					reg_write <= 1'b1;
					alu_op <= cpu_pkg::alu_lui;
				end
				cpu_pkg::op_lw: begin
					reg_write <= 1'b1;
					mem_read <= 1'b1;
					wb_src <= cpu_pkg::wb_mem;
				end
				cpu_pkg::op_sw: mem_write <= 1'b1;
				cpu_pkg::op_beq: branch_eq <= 1'b1;
				cpu_pkg::op_bne: branch_ne <= 1'b1;
				cpu_pkg::op_j: jump <= 1'b1;
				cpu_pkg::op_uart: begin
					// IN writes rd, OUT sends rs
					rd_dst <= inst.r.rd;
					wb_src <= cpu_pkg::wb_uart;
					reg_write <= inst.r.funct == cpu_pkg::fn_in;
					uart_out <= inst.r.funct == cpu_pkg::fn_out;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/operand_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_fetch (
	input logic CLK,
	input logic reset,
	input logic dec_valid,
	input logic [4:0] rs, rt,
	input logic wr_en,
	input logic [4:0] wr_addr,
	input logic [31:0] wr_data,
	input logic [4:0] rd_dst,
	input logic [3:0] alu_op,
	input logic use_imm, sign_ext, mem_read, mem_write, reg_write,
	input logic [1:0] wb_src,
	input logic branch_eq, branch_ne, jump, uart_out,
	input logic [15:0] imm,
	input logic [cpu_pkg::inst_addr_w-1:0] jump_index, pc,
	output logic op_valid,
	output logic [31:0] op_a, op_b,
	output logic [4:0] op_rd_dst,
	output logic [3:0] op_alu_op,
	output logic op_use_imm, op_sign_ext, op_mem_read, op_mem_write, op_reg_write,
	output logic [1:0] op_wb_src,
	output logic op_branch_eq, op_branch_ne, op_jump, op_uart_out,
	output logic [15:0] op_imm,
	output logic [cpu_pkg::inst_addr_w-1:0] op_jump_index, op_pc
);

	logic [31:0] regs [32];

	always_ff @(posedge CLK) begin
		if (reset) begin
			op_valid <= 1'b0;
		end else begin
			op_valid <= dec_valid;
		end
	end

	// r0 is never stored, reads force zero
	always_ff @(posedge CLK) begin
		if (wr_en && wr_addr != 5'd0) regs[wr_addr] <= wr_data;
	end

	always_ff @(posedge CLK) begin
		if (dec_valid) begin
			op_a <= (rs == 5'd0) ? 32'd0 : regs[rs];
			op_b <= (rt == 5'd0) ? 32'd0 : regs[rt];
			op_rd_dst <= rd_dst;
			op_alu_op <= alu_op;
			op_use_imm <= use_imm;
			op_sign_ext <= sign_ext;
			op_mem_read <= mem_read;
			op_mem_write <= mem_write;
			op_reg_write <= reg_write;
			op_wb_src <= wb_src;
			op_branch_eq <= branch_eq;
			op_branch_ne <= branch_ne;
			op_jump <= jump;
			op_uart_out <= uart_out;
			op_imm <= imm;
			op_jump_index <= jump_index;
			op_pc <= pc;
		end
	end

endmodule

`default_nettype wire

/* design/execution.sv */
`timescale 1ns/1ps
`default_nettype none

module execution (
	input logic CLK,
	input logic reset,
	input logic op_valid,
	input logic [31:0] op_a, op_b,
	input logic [4:0] op_rd_dst,
	input logic [3:0] op_alu_op,
	input logic op_use_imm, op_sign_ext, op_mem_read, op_mem_write, op_reg_write,
	input logic [1:0] op_wb_src,
	input logic op_branch_eq, op_branch_ne, op_jump, op_uart_out,
	input logic [15:0] op_imm,
	input logic [cpu_pkg::inst_addr_w-1:0] op_jump_index, op_pc,
	output logic ex_valid,
	output logic [31:0] result, store_data,
	output logic take_branch,
	output logic [cpu_pkg::inst_addr_w-1:0] target,
	output logic out_start,
	output logic [31:0] out_word,
	output logic [4:0] ex_rd_dst,
	output logic ex_mem_read, ex_mem_write, ex_reg_write,
	output logic [1:0] ex_wb_src,
	output logic [cpu_pkg::inst_addr_w-1:0] ex_pc
);

	logic [31:0] ext_imm, src_b, alu_y;
	logic equal;

	assign ext_imm = op_sign_ext ? {{16{op_imm[15]}}, op_imm} : {16'd0, op_imm};
	assign src_b = op_use_imm ? ext_imm : op_b;
	assign equal = op_a == op_b;

	// sender latches the word right away
	assign out_start = op_valid && op_uart_out;
	assign out_word = op_a;

	always_comb begin
		case (op_alu_op)
			cpu_pkg::alu_sub: alu_y = op_a - src_b;
			cpu_pkg::alu_and: alu_y = op_a & src_b;
			cpu_pkg::alu_or: alu_y = op_a | src_b;
			cpu_pkg::alu_slt: alu_y = {31'd0, $signed(op_a) < $signed(src_b)};
			// shamt sits in imm[10:6] of the R form
			cpu_pkg::alu_sll: alu_y = src_b << op_imm[10:6];
			cpu_pkg::alu_lui: alu_y = {op_imm, 16'd0};
			default: alu_y = op_a + src_b;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= op_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (op_valid) begin
			result <= alu_y;
			store_data <= op_b;
			take_branch <= op_jump || (op_branch_eq && equal) || (op_branch_ne && !equal);
			// offset wraps within the word address space
			target <= op_jump ? op_jump_index
				: op_pc + 1'b1 + op_imm[cpu_pkg::inst_addr_w-1:0];
			ex_rd_dst <= op_rd_dst;
			ex_mem_read <= op_mem_read;
			ex_mem_write <= op_mem_write;
			ex_reg_write <= op_reg_write;
			ex_wb_src <= op_wb_src;
			ex_pc <= op_pc;
		end
	end

endmodule

`default_nettype wire

/* design/memory_access.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_access (
	input logic CLK,
	input logic reset,
	input logic ex_valid,
	input logic [31:0] result, store_data,
	input logic mem_read, mem_write,
	input logic [4:0] ex_rd_dst,
	input logic ex_reg_write,
	input logic [1:0] ex_wb_src,
	input logic take_branch,
	input logic [cpu_pkg::inst_addr_w-1:0] target, ex_pc,
	output logic mem_valid,
	output logic [31:0] mem_data,
	output logic [4:0] mem_rd_dst,
	output logic mem_reg_write,
	output logic [1:0] mem_wb_src,
	output logic mem_take_branch,
	output logic [cpu_pkg::inst_addr_w-1:0] mem_target, mem_pc
);

	logic [31:0] dmem [2**cpu_pkg::data_addr_w];
	logic [cpu_pkg::data_addr_w-1:0] addr;

	// byte address, word aligned
	assign addr = result[cpu_pkg::data_addr_w+1:2];

	always_ff @(posedge CLK) begin
		if (reset) begin
			mem_valid <= 1'b0;
		end else begin
			mem_valid <= ex_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (ex_valid) begin
			if (mem_write) dmem[addr] <= store_data;
			if (mem_read) mem_data <= dmem[addr];
			mem_rd_dst <= ex_rd_dst;
			mem_reg_write <= ex_reg_write;
			mem_wb_src <= ex_wb_src;
			mem_take_branch <= take_branch;
			mem_target <= target;
			mem_pc <= ex_pc;
		end
	end

endmodule

`default_nettype wire

/* design/write_back_pc.sv */
`timescale 1ns/1ps
`default_nettype none

module write_back_pc (
	input logic CLK,
	input logic reset,
	input logic mem_valid,
	input logic [31:0] result, mem_data,
	input logic in_ready,
	input logic [31:0] in_word,
	input logic [4:0] mem_rd_dst,
	input logic mem_reg_write,
	input logic [1:0] mem_wb_src,
	input logic mem_take_branch,
	input logic [cpu_pkg::inst_addr_w-1:0] mem_target, mem_pc,
	output logic wr_en,
	output logic [4:0] wr_addr,
	output logic [31:0] wr_data,
	output logic in_pop,
	output logic [cpu_pkg::inst_addr_w-1:0] next_pc,
	output logic start
);

	logic waiting, is_in, done;

	// result is still held by execution, nothing else is in flight
	assign is_in = mem_wb_src == cpu_pkg::wb_uart && mem_reg_write;
	assign done = (mem_valid || waiting) && (!is_in || in_ready);
	assign in_pop = done && is_in;

	always_ff @(posedge CLK) begin
		if (reset) begin
			waiting <= 1'b0;
			wr_en <= 1'b0;
			start <= 1'b0;
		end else begin
			start <= done;
			wr_en <= done && mem_reg_write;
			if (done) begin
				waiting <= 1'b0;
			end else if (mem_valid) begin
				waiting <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (done) begin
			wr_addr <= mem_rd_dst;
			next_pc <= mem_take_branch ? mem_target : mem_pc + 1'b1;
			case (mem_wb_src)
				cpu_pkg::wb_mem: wr_data <= mem_data;
				cpu_pkg::wb_uart: wr_data <= in_word;
				default: wr_data <= result;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
	input logic CLK,
	input logic reset,
	input logic [7:0] rx_data,
	input logic rx_valid,
	input logic load,
	output logic [7:0] tx_data,
	output logic tx_valid
);

	// link side
	logic imem_we, in_ready, in_pop, out_start, busy;
	logic [31:0] imem_data, in_word, out_word;

	// fetch and decode
	logic start, fetch_valid, dec_valid;
	logic [cpu_pkg::inst_addr_w-1:0] next_pc, pc, pc_out, jump_index;
	cpu_pkg::inst_word_t inst;
	logic [4:0] rs, rt, rd_dst;
	logic [3:0] alu_op;
	logic use_imm, sign_ext, mem_read, mem_write, reg_write;
	logic branch_eq, branch_ne, jump, uart_out;
	logic [1:0] wb_src;
	logic [15:0] imm;

	// operand fetch
	logic wr_en, op_valid;
	logic [4:0] wr_addr, op_rd_dst;
	logic [31:0] wr_data, op_a, op_b;
	logic [3:0] op_alu_op;
	logic op_use_imm, op_sign_ext, op_mem_read, op_mem_write, op_reg_write;
	logic op_branch_eq, op_branch_ne, op_jump, op_uart_out;
	logic [1:0] op_wb_src;
	logic [15:0] op_imm;
	logic [cpu_pkg::inst_addr_w-1:0] op_jump_index, op_pc;

	// execution and memory
	logic ex_valid, take_branch, ex_mem_read, ex_mem_write, ex_reg_write;
	logic [31:0] result, store_data, mem_data;
	logic [4:0] ex_rd_dst, mem_rd_dst;
	logic [1:0] ex_wb_src, mem_wb_src;
	logic [cpu_pkg::inst_addr_w-1:0] target, ex_pc, mem_target, mem_pc;
	logic mem_valid, mem_reg_write, mem_take_branch;

	receiver_buffer u_rx (.*);
	sender_buffer u_tx (.*);
	inst_fetch u_if (.*);
	inst_decode u_id (.*);
	operand_fetch u_of (.*, .pc(pc_out));
	execution u_ex (.*);
	memory_access u_mem (.*, .mem_read(ex_mem_read), .mem_write(ex_mem_write));
	write_back_pc u_wb (.*);

endmodule

`default_nettype wire

/* verification/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

	logic CLK = 1'b0;
	logic reset;
	logic [7:0] rx_data;
	logic rx_valid;
	logic load;
	logic [7:0] tx_data;
	logic tx_valid;

	// program, input words and expected output words of the current test
	logic [31:0] prog [$];
	logic [31:0] in_words [$];
	logic [31:0] exp_q [$];
	logic [31:0] lcg_state = 32'hfaef_03b2;
	logic [31:0] rx_word;
	int ref_steps;
	int budget = 100;
	int cycles = 0;
	int sent = 0;
	int popped = 0;
	int byte_idx = 0;

	cpu_top uut (
		.CLK(CLK),
		.reset(reset),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.load(load),
		.tx_data(tx_data),
		.tx_valid(tx_valid)
	);

	always #20 CLK = ~CLK;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic void put_r(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] shamt);
		cpu_pkg::inst_word_t w;
		w.r.opcode = cpu_pkg::op_special;
		w.r.rs = rs;
		w.r.rt = rt;
		w.r.rd = rd;
		w.r.shamt = shamt;
		w.r.funct = fn;
		prog.push_back(w);
	endfunction

	function automatic void put_i(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		cpu_pkg::inst_word_t w;
		w.i.opcode = op;
		w.i.rs = rs;
		w.i.rt = rt;
		w.i.imm = imm;
		prog.push_back(w);
	endfunction

	function automatic void put_j(input int target);
		cpu_pkg::inst_word_t w;
		w.j.opcode = cpu_pkg::op_j;
		w.j.index = 26'(target);
		prog.push_back(w);
	endfunction

	function automatic void put_uart(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs);
		cpu_pkg::inst_word_t w;
		w.r.opcode = cpu_pkg::op_uart;
		w.r.rs = rs;
		w.r.rt = 5'd0;
		w.r.rd = rd;
		w.r.shamt = 5'd0;
		w.r.funct = fn;
		prog.push_back(w);
	endfunction

	function automatic void put_in(input logic [4:0] rd);
		put_uart(cpu_pkg::fn_in, rd, 5'd0);
	endfunction

	function automatic void put_out(input logic [4:0] rs);
		put_uart(cpu_pkg::fn_out, 5'd0, rs);
	endfunction

	// branch offset from the instruction about to be emitted
	function automatic logic [15:0] rel(input int target);
		return 16'(target - prog.size() - 1);
	endfunction

	// ISA model that runs until a jump to itself
	function automatic void run_ref();
		logic [31:0] regs [32];
		logic [31:0] dmem [2**cpu_pkg::data_addr_w];
		cpu_pkg::inst_word_t w;
		logic [31:0] a, b, imm_s, val, addr_v;
		logic [4:0] wr_idx;
		logic wr;
		int pc, npc, in_idx, amask, i;
		amask = (1 << cpu_pkg::inst_addr_w) - 1;
		for (i = 0; i < 32; i++) begin
			regs[i] = 32'd0;
		end
		for (i = 0; i < 2**cpu_pkg::data_addr_w; i++) begin
			dmem[i] = 32'd0;
		end
		pc = 0;
		in_idx = 0;
		ref_steps = 0;
		while (ref_steps < 20000 && pc < prog.size()) begin
			w = prog[pc];
			a = regs[w.r.rs];
			b = regs[w.r.rt];
			imm_s = {{16{w.i.imm[15]}}, w.i.imm};
			addr_v = a + imm_s;
			npc = (pc + 1) & amask;
			wr = 1'b0;
			wr_idx = w.i.rt;
			val = 32'd0;
			ref_steps++;
			case (w.r.opcode)
				cpu_pkg::op_special: begin
					wr = 1'b1;
					wr_idx = w.r.rd;
					case (w.r.funct)
						cpu_pkg::fn_addu: val = a + b;
						cpu_pkg::fn_subu: val = a - b;
						cpu_pkg::fn_and: val = a & b;
						cpu_pkg::fn_or: val = a | b;
						cpu_pkg::fn_slt: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						cpu_pkg::fn_sll: val = b << w.r.shamt;
						default: val = 32'd0;
					endcase
				end
				cpu_pkg::op_addiu: begin
					wr = 1'b1;
					val = a + imm_s;
				end
				cpu_pkg::op_ori: begin
					wr = 1'b1;
					val = a | {16'd0, w.i.imm};
				end
				cpu_pkg::op_lui: begin
					wr = 1'b1;
					val = {w.i.imm, 16'd0};
				end
				cpu_pkg::op_lw: begin
					wr = 1'b1;
					val = dmem[addr_v[cpu_pkg::data_addr_w+1:2]];
				end
				cpu_pkg::op_sw: dmem[addr_v[cpu_pkg::data_addr_w+1:2]] = b;
				cpu_pkg::op_beq: begin
					if (a == b) begin
						npc = (pc + 1 + int'($signed(w.i.imm))) & amask;
					end
				end
				cpu_pkg::op_bne: begin
					if (a != b) begin
						npc = (pc + 1 + int'($signed(w.i.imm))) & amask;
					end
				end
				cpu_pkg::op_j: npc = int'(w.j.index) & amask;
				cpu_pkg::op_uart: begin
					if (w.r.funct == cpu_pkg::fn_in) begin
						if (in_idx >= in_words.size()) begin
							break;
						end
						wr = 1'b1;
						wr_idx = w.r.rd;
						val = in_words[in_idx];
						in_idx++;
					end else begin
						exp_q.push_back(a);
					end
				end
				default: ;
			endcase
			if (wr && wr_idx != 5'd0) begin
				regs[wr_idx] = val;
			end
			if (w.r.opcode == cpu_pkg::op_j && npc == pc) begin
				break;
			end
			pc = npc;
		end
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] want,
		input string what);
		if (got !== want) begin
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, want);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic send_word(input logic [31:0] w);
		int k;
		for (k = 0; k < 4; k++) begin
			@(posedge CLK);
			#2;
			rx_data = w[8*k +: 8];
			rx_valid = 1'b1;
		end
		@(posedge CLK);
		#2;
		rx_valid = 1'b0;
	endtask

	task automatic load_program();
		int i;
		@(posedge CLK);
		#2;
		load = 1'b1;
		repeat (2) @(posedge CLK);
		for (i = 0; i < prog.size(); i++) begin
			send_word(prog[i]);
		end
		repeat (3) @(posedge CLK);
		#2;
		load = 1'b0;
		repeat (3) @(posedge CLK);
	endtask

	// keep at most rx_depth words waiting in the queue
	task automatic feed_inputs();
		int i;
		for (i = 0; i < in_words.size(); i++) begin
			while (sent - popped >= cpu_pkg::rx_depth) begin
				@(posedge CLK);
			end
			send_word(in_words[i]);
			sent++;
		end
	endtask

	task automatic run_test(input string name);
		int n;
		run_ref();
		n = exp_q.size();
		budget += 40 * ref_steps + 32 * (prog.size() + in_words.size() + n) + 200;
		load_program();
		feed_inputs();
		while (exp_q.size() != 0) begin
			@(posedge CLK);
		end
		repeat (40) @(posedge CLK);
		$display("%s: %0d output words matched", name, n);
	endtask

	function automatic void echo_program();
		int i;
		prog.delete();
		in_words.delete();
		in_words.push_back(32'h4433_2211);
		for (i = 1; i < 8; i++) begin
			in_words.push_back(lcg_next());
		end
		put_i(cpu_pkg::op_addiu, 5'd2, 5'd0, 16'd8);
		put_in(5'd1);
		put_out(5'd1);
		put_i(cpu_pkg::op_addiu, 5'd2, 5'd2, 16'hffff);
		put_i(cpu_pkg::op_bne, 5'd0, 5'd2, rel(1));
		put_j(prog.size());
	endfunction

	function automatic void alu_program();
		logic [31:0] r;
		int p;
		prog.delete();
		in_words.delete();
		for (p = 0; p < 4; p++) begin
			r = lcg_next();
			in_words.push_back(r);
			// last pair equal for slt
			in_words.push_back(p == 3 ? r : lcg_next());
			put_in(5'd1);
			put_in(5'd2);
			put_r(cpu_pkg::fn_addu, 5'd3, 5'd1, 5'd2, 5'd0);
			put_out(5'd3);
			put_r(cpu_pkg::fn_subu, 5'd3, 5'd1, 5'd2, 5'd0);
			put_out(5'd3);
			put_r(cpu_pkg::fn_and, 5'd3, 5'd1, 5'd2, 5'd0);
			put_out(5'd3);
			put_r(cpu_pkg::fn_or, 5'd3, 5'd1, 5'd2, 5'd0);
			put_out(5'd3);
			put_r(cpu_pkg::fn_slt, 5'd3, 5'd1, 5'd2, 5'd0);
			put_out(5'd3);
			r = lcg_next();
			put_r(cpu_pkg::fn_sll, 5'd3, 5'd0, 5'd2, r[4:0]);
			put_out(5'd3);
			put_i(cpu_pkg::op_addiu, 5'd3, 5'd1, r[31:16]);
			put_out(5'd3);
			r = lcg_next();
			put_i(cpu_pkg::op_ori, 5'd3, 5'd1, r[15:0]);
			put_out(5'd3);
			put_i(cpu_pkg::op_lui, 5'd3, 5'd0, r[31:16]);
			put_out(5'd3);
		end
		put_j(prog.size());
	endfunction

	function automatic void memory_program();
		int k;
		prog.delete();
		in_words.delete();
		put_i(cpu_pkg::op_addiu, 5'd5, 5'd0, 16'h0200);
		for (k = 0; k < 5; k++) begin
			in_words.push_back(lcg_next());
			put_in(5'd1);
			put_i(cpu_pkg::op_sw, 5'd1, 5'd5, 16'(k * 20 - 40));
		end
		// read back in reverse order
		for (k = 4; k >= 0; k--) begin
			put_i(cpu_pkg::op_lw, 5'd2, 5'd5, 16'(k * 20 - 40));
			put_out(5'd2);
		end
		put_j(prog.size());
	endfunction

	function automatic void branch_program();
		int n, loop;
		prog.delete();
		in_words.delete();
		n = 3 + int'(lcg_next() % 32'd5);
		put_i(cpu_pkg::op_addiu, 5'd1, 5'd0, 16'd0);
		put_i(cpu_pkg::op_addiu, 5'd2, 5'd0, 16'(n));
		loop = prog.size();
		put_r(cpu_pkg::fn_addu, 5'd1, 5'd1, 5'd2, 5'd0);
		put_out(5'd1);
		put_i(cpu_pkg::op_addiu, 5'd2, 5'd2, 16'hffff);
		put_i(cpu_pkg::op_bne, 5'd0, 5'd2, rel(loop));
		put_i(cpu_pkg::op_beq, 5'd1, 5'd1, 16'd1);
		put_out(5'd2);
		// not taken because the sum is nonzero
		put_i(cpu_pkg::op_beq, 5'd0, 5'd1, 16'd1);
		put_out(5'd1);
		put_j(prog.size() + 2);
		put_out(5'd2);
		put_i(cpu_pkg::op_ori, 5'd3, 5'd0, 16'h1234);
		put_out(5'd3);
		put_j(prog.size());
	endfunction

	function automatic void zero_reg_program();
		prog.delete();
		in_words.delete();
		in_words.push_back(lcg_next());
		put_i(cpu_pkg::op_addiu, 5'd0, 5'd0, 16'h0055);
		put_out(5'd0);
		put_i(cpu_pkg::op_lui, 5'd0, 5'd0, 16'hdead);
		put_r(cpu_pkg::fn_addu, 5'd4, 5'd0, 5'd0, 5'd0);
		put_out(5'd4);
		put_in(5'd0);
		put_out(5'd0);
		put_j(prog.size());
	endfunction

	// shorter than the previous one so its old words stay behind it
	function automatic void reload_program();
		prog.delete();
		in_words.delete();
		put_i(cpu_pkg::op_addiu, 5'd6, 5'd0, 16'd7);
		put_r(cpu_pkg::fn_sll, 5'd6, 5'd0, 5'd6, 5'd3);
		put_out(5'd6);
		put_j(prog.size());
	endfunction

	always @(negedge CLK) begin
		if (!reset && uut.in_pop === 1'b1) begin
			popped++;
		end
	end

	// byte k of a word arrives k-th
	always @(negedge CLK) begin
		if (!reset && tx_valid === 1'b1) begin
			rx_word[8*byte_idx +: 8] = tx_data;
			if (byte_idx == 3) begin
				byte_idx = 0;
				if (exp_q.size() == 0) begin
					$display("unexpected output word %h at %0t", rx_word, $time);
					$display("*** FAILED ***");
					$fatal(1);
				end else begin
					check_value(rx_word, exp_q.pop_front(), "output word");
				end
			end else begin
				byte_idx++;
			end
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles > budget) begin
			$display("timeout: run did not finish within %0d cycles", budget);
			$display("*** FAILED ***");
			$fatal(1);
		end
	end

	initial begin
		reset = 1'b1;
		rx_data = 8'd0;
		rx_valid = 1'b0;
		load = 1'b0;
		repeat (2) @(posedge CLK);
		#2;
		reset = 1'b0;
		echo_program();
		run_test("echo");
		alu_program();
		run_test("alu");
		memory_program();
		run_test("memory");
		branch_program();
		run_test("control flow");
		zero_reg_program();
		run_test("register 0");
		reload_program();
		run_test("reload");
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
design/cpu_pkg.sv
design/receiver_buffer.sv
design/sender_buffer.sv
design/inst_fetch.sv
design/inst_decode.sv
design/operand_fetch.sv
design/execution.sv
design/memory_access.sv
design/write_back_pc.sv
design/cpu_top.sv
verification/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= cpu_tb
RTL_TOP ?= cpu_top
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || { echo "simulation did not finish"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
